//--- hw/i8008_pkg.sv
package i8008_pkg;

  localparam int DATA_W   = 8;
  localparam int ADDR_W   = 14;
  localparam int NUM_REGS = 7;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Bus states, one clock each
  typedef enum logic [2:0] {T1, T2, WAIT, T3, T4, T5, STOPPED} state_t;

  typedef enum logic [1:0] {CYCLE1, CYCLE2, CYCLE3} cycle_t;

  // Shown in bits 7:6 of the T2 byte
  typedef enum logic [1:0] {PCI, PCR, PCC, PCW} cycle_type_t;

  // Same codes as the SSS/DDD fields
  typedef enum logic [2:0] {REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L} reg_sel_t;

  // Instruction bits 5:3 of the ALU group
  typedef enum logic [2:0] {ADD, ADC, SUB, SBB, AND, XOR, OR, CMP} alu_op_t;

  typedef enum logic [2:0] {INC, DEC, RLC, RRC, RAL, RAR} rot_op_t;

  typedef enum logic [1:0] {COND_C, COND_Z, COND_S, COND_P} cond_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic parity; // Set on an even number of ones
  } flags_t;

  typedef enum logic [2:0] {NONE, PC_LO, PC_HI, REG, ALU, TMP_A, TMP_B, DATA_IN} bus_src_t;

  typedef struct packed {
    bus_src_t    bus_src;
    reg_sel_t    reg_sel;
    logic        reg_we;
    logic        tmp_a_we;
    logic        tmp_b_we;
    logic        ir_we;
    alu_op_t     alu_op;
    logic        alu_rotate; // Use rot_op instead of alu_op
    rot_op_t     rot_op;
    logic        flag_we;
    logic        pc_inc;
    logic        pc_load;
    logic        mark_cycle;
    cycle_type_t cycle_type;
  } ctrl_t;

endpackage

//--- hw/i8008_alu.sv
`timescale 1ns/1ps

module i8008_alu (
  input  i8008_pkg::data_t     a,
  input  i8008_pkg::data_t     b,
  input  i8008_pkg::alu_op_t   op,
  input  logic                 rotate,
  input  i8008_pkg::rot_op_t   rot_op,
  input  i8008_pkg::flags_t    flags_in,
  output i8008_pkg::data_t     result,
  output i8008_pkg::flags_t    flags_next
);

  logic [i8008_pkg::DATA_W:0] sum; // Top bit is carry or borrow

  always_comb begin
    sum        = '0;
    result     = a;
    flags_next = flags_in;
    if (rotate) begin
      case (rot_op)
        i8008_pkg::INC: result = a + 8'd1;
        i8008_pkg::DEC: result = a - 8'd1;
        i8008_pkg::RLC: {flags_next.carry, result} = {a[7], a[6:0], a[7]};
        i8008_pkg::RRC: {flags_next.carry, result} = {a[0], a[0], a[7:1]};
        i8008_pkg::RAL: {flags_next.carry, result} = {a[7], a[6:0], flags_in.carry};
        i8008_pkg::RAR: {flags_next.carry, result} = {a[0], flags_in.carry, a[7:1]};
        default: ;
      endcase
      // Increment and decrement leave carry alone
      if (rot_op == i8008_pkg::INC || rot_op == i8008_pkg::DEC) begin
        flags_next.zero   = (result == '0);
        flags_next.sign   = result[7];
        flags_next.parity = ~^result;
      end
    end else begin
      case (op)
        i8008_pkg::ADD: sum = {1'b0, a} + {1'b0, b};
        i8008_pkg::ADC: sum = {1'b0, a} + {1'b0, b} + 9'(flags_in.carry);
        i8008_pkg::SUB: sum = {1'b0, a} - {1'b0, b};
        i8008_pkg::SBB: sum = {1'b0, a} - {1'b0, b} - 9'(flags_in.carry);
        i8008_pkg::AND: sum = {1'b0, a & b};
        i8008_pkg::XOR: sum = {1'b0, a ^ b};
        i8008_pkg::OR:  sum = {1'b0, a | b};
        i8008_pkg::CMP: sum = {1'b0, a} - {1'b0, b};
        default: ;
      endcase
      result            = (op == i8008_pkg::CMP) ? a : sum[7:0]; // Compare keeps A
      flags_next.carry  = sum[8];
      flags_next.zero   = (sum[7:0] == '0);
      flags_next.sign   = sum[7];
      flags_next.parity = ~^sum[7:0];
    end
  end

endmodule

//--- hw/i8008_regfile.sv
`timescale 1ns/1ps

module i8008_regfile (
  input  logic                clk,
  input  logic                rst,
  input  i8008_pkg::reg_sel_t sel,
  input  logic                we,
  input  i8008_pkg::data_t    wdata,
  output i8008_pkg::data_t    rdata,
  output i8008_pkg::data_t    acc
);

  i8008_pkg::data_t regs [i8008_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < i8008_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[sel] <= wdata;
    end
  end

  assign rdata = regs[sel];
  assign acc   = regs[i8008_pkg::REG_A]; // Feeds temp A for ALU ops

endmodule

//--- hw/i8008_sequencer.sv
`timescale 1ns/1ps

module i8008_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              ready,
  input  i8008_pkg::data_t  instr,
  input  i8008_pkg::flags_t flags,
  output i8008_pkg::ctrl_t  ctrl,
  output i8008_pkg::state_t state
);

  i8008_pkg::cycle_t   cycle;
  i8008_pkg::state_t   next_state;
  i8008_pkg::cycle_t   next_cycle;
  i8008_pkg::reg_sel_t sss;
  i8008_pkg::reg_sel_t ddd;
  logic is_hlt, is_mov, is_lmr, is_alur, is_incdec, is_rot;
  logic is_lri, is_alui, is_jmp, is_jcc;
  logic multi_cycle, cond_flag, take_jump;

  assign sss = i8008_pkg::reg_sel_t'(instr[2:0]);
  assign ddd = i8008_pkg::reg_sel_t'(instr[5:3]);

  // Instruction classes, M operands excluded
  assign is_hlt    = (instr == 8'hff) || (instr[7:1] == 7'b0000000);
  assign is_mov    = (instr[7:6] == 2'b11) && (instr[5:3] != 3'b111) && (instr[2:0] != 3'b111);
  assign is_lmr    = (instr[7:3] == 5'b11111) && (instr[2:0] != 3'b111);
  assign is_alur   = (instr[7:6] == 2'b10) && (instr[2:0] != 3'b111);
  assign is_incdec = (instr[7:6] == 2'b00) && (instr[2:1] == 2'b00) && (instr[5:3] != 3'b000);
  assign is_rot    = (instr[7:5] == 3'b000) && (instr[2:0] == 3'b010);
  assign is_lri    = (instr[7:6] == 2'b00) && (instr[2:0] == 3'b110) && (instr[5:3] != 3'b111);
  assign is_alui   = (instr[7:6] == 2'b00) && (instr[2:0] == 3'b100);
  assign is_jmp    = (instr[7:6] == 2'b01) && (instr[2:0] == 3'b100);
  assign is_jcc    = (instr[7:6] == 2'b01) && (instr[2:0] == 3'b000);

  assign multi_cycle = is_lri || is_alui || is_lmr || is_jmp || is_jcc;

  always_comb begin
    case (i8008_pkg::cond_t'(instr[4:3]))
      i8008_pkg::COND_C: cond_flag = flags.carry;
      i8008_pkg::COND_Z: cond_flag = flags.zero;
      i8008_pkg::COND_S: cond_flag = flags.sign;
      default:           cond_flag = flags.parity;
    endcase
  end

  // Bit 5 selects jump-if-true or jump-if-false
  assign take_jump = is_jmp || (is_jcc && (cond_flag == instr[5]));

  always_comb begin
    next_state = state;
    next_cycle = cycle;
    case (state)
      i8008_pkg::T1:                 next_state = i8008_pkg::T2;
      i8008_pkg::T2, i8008_pkg::WAIT: next_state = ready ? i8008_pkg::T3 : i8008_pkg::WAIT;
      i8008_pkg::T3: begin
        next_state = i8008_pkg::T1;
        next_cycle = i8008_pkg::CYCLE1;
        if ((cycle == i8008_pkg::CYCLE1) || (cycle == i8008_pkg::CYCLE2 && is_alui) ||
            (cycle == i8008_pkg::CYCLE3 && take_jump)) begin
          next_state = i8008_pkg::T4;
          next_cycle = cycle;
        end else if (cycle == i8008_pkg::CYCLE2 && (is_jmp || is_jcc)) begin
          next_cycle = i8008_pkg::CYCLE3; // High address byte still to come
        end
      end
      i8008_pkg::T4: next_state = i8008_pkg::T5;
      i8008_pkg::T5: begin
        next_state = i8008_pkg::T1;
        next_cycle = i8008_pkg::CYCLE1;
        if (cycle == i8008_pkg::CYCLE1 && is_hlt) begin
          next_state = i8008_pkg::STOPPED;
        end else if (cycle == i8008_pkg::CYCLE1 && multi_cycle) begin
          next_cycle = i8008_pkg::CYCLE2;
        end
      end
      default: ; // STOPPED until reset
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (state)
      i8008_pkg::T1: begin
        ctrl.bus_src = i8008_pkg::PC_LO;
        if (cycle == i8008_pkg::CYCLE2 && is_lmr) begin
          ctrl.bus_src = i8008_pkg::REG; // Write address from H:L
          ctrl.reg_sel = i8008_pkg::REG_L;
        end
      end
      i8008_pkg::T2: begin
        ctrl.mark_cycle = 1'b1;
        if (cycle == i8008_pkg::CYCLE2 && is_lmr) begin
          ctrl.bus_src    = i8008_pkg::REG;
          ctrl.reg_sel    = i8008_pkg::REG_H;
          ctrl.cycle_type = i8008_pkg::PCW;
        end else begin
          ctrl.bus_src    = i8008_pkg::PC_HI;
          ctrl.pc_inc     = 1'b1;
          ctrl.cycle_type = (cycle == i8008_pkg::CYCLE1) ? i8008_pkg::PCI : i8008_pkg::PCR;
        end
      end
      i8008_pkg::T3: begin
        ctrl.bus_src = i8008_pkg::DATA_IN;
        if (cycle == i8008_pkg::CYCLE1) begin
          ctrl.ir_we = 1'b1;
        end else if (cycle == i8008_pkg::CYCLE2) begin
          ctrl.reg_sel  = ddd;
          ctrl.reg_we   = is_lri;
          ctrl.tmp_a_we = is_alui;
          ctrl.tmp_b_we = is_alui || is_jmp || is_jcc; // Immediate or jump low byte
          if (is_lmr) begin
            ctrl.bus_src = i8008_pkg::TMP_B;
          end
        end else begin
          ctrl.tmp_a_we = 1'b1; // Jump high byte
        end
      end
      i8008_pkg::T4: begin
        if (cycle == i8008_pkg::CYCLE1 && (is_alur || is_mov || is_lmr)) begin
          ctrl.bus_src  = i8008_pkg::REG;
          ctrl.reg_sel  = sss;
          ctrl.tmp_b_we = 1'b1;
          ctrl.tmp_a_we = is_alur; // Pairs with the accumulator
        end else if (cycle == i8008_pkg::CYCLE1 && (is_incdec || is_rot)) begin
          ctrl.bus_src  = i8008_pkg::REG;
          ctrl.reg_sel  = is_rot ? i8008_pkg::REG_A : ddd;
          ctrl.tmp_a_we = 1'b1;
        end
        ctrl.pc_load = (cycle == i8008_pkg::CYCLE3);
      end
      i8008_pkg::T5: begin
        ctrl.bus_src = i8008_pkg::ALU;
        ctrl.reg_sel = i8008_pkg::REG_A;
        ctrl.alu_op  = i8008_pkg::alu_op_t'(instr[5:3]);
        if ((cycle == i8008_pkg::CYCLE1 && is_alur) || (cycle == i8008_pkg::CYCLE2 && is_alui)) begin
          ctrl.reg_we  = 1'b1;
          ctrl.flag_we = 1'b1;
        end else if (cycle == i8008_pkg::CYCLE1 && is_incdec) begin
          ctrl.reg_sel    = ddd;
          ctrl.reg_we     = 1'b1;
          ctrl.flag_we    = 1'b1;
          ctrl.alu_rotate = 1'b1;
          ctrl.rot_op     = instr[0] ? i8008_pkg::DEC : i8008_pkg::INC;
        end else if (cycle == i8008_pkg::CYCLE1 && is_rot) begin
          ctrl.reg_we     = 1'b1;
          ctrl.flag_we    = 1'b1;
          ctrl.alu_rotate = 1'b1;
          ctrl.rot_op     = i8008_pkg::rot_op_t'({1'b0, instr[4:3]} + 3'd2);
        end else if (cycle == i8008_pkg::CYCLE1 && is_mov) begin
          ctrl.bus_src = i8008_pkg::TMP_B;
          ctrl.reg_sel = ddd;
          ctrl.reg_we  = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= i8008_pkg::T1;
      cycle <= i8008_pkg::CYCLE1;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
    end
  end

endmodule

//--- hw/i8008_datapath.sv
`timescale 1ns/1ps

module i8008_datapath (
  input  logic              clk,
  input  logic              rst,
  input  i8008_pkg::ctrl_t  ctrl,
  input  i8008_pkg::data_t  data_in,
  output i8008_pkg::data_t  data_out,
  output i8008_pkg::data_t  instr,
  output i8008_pkg::flags_t flags
);

  i8008_pkg::data_t  bus;
  i8008_pkg::data_t  ir;
  i8008_pkg::data_t  tmp_a;
  i8008_pkg::data_t  tmp_b;
  i8008_pkg::data_t  reg_rdata;
  i8008_pkg::data_t  acc;
  i8008_pkg::data_t  alu_result;
  i8008_pkg::flags_t alu_flags;
  i8008_pkg::addr_t  pc;

  i8008_regfile i_regfile (
    .clk   (clk),
    .rst   (rst),
    .sel   (ctrl.reg_sel),
    .we    (ctrl.reg_we),
    .wdata (bus),
    .rdata (reg_rdata),
    .acc   (acc)
  );

  i8008_alu i_alu (
    .a          (tmp_a),
    .b          (tmp_b),
    .op         (ctrl.alu_op),
    .rotate     (ctrl.alu_rotate),
    .rot_op     (ctrl.rot_op),
    .flags_in   (flags),
    .result     (alu_result),
    .flags_next (alu_flags)
  );

  always_comb begin
    case (ctrl.bus_src)
      i8008_pkg::PC_LO:   bus = pc[i8008_pkg::DATA_W-1:0];
      i8008_pkg::PC_HI:   bus = i8008_pkg::data_t'(pc[i8008_pkg::ADDR_W-1:i8008_pkg::DATA_W]);
      i8008_pkg::REG:     bus = reg_rdata;
      i8008_pkg::ALU:     bus = alu_result;
      i8008_pkg::TMP_B:   bus = tmp_b;
      i8008_pkg::DATA_IN: bus = data_in;
      default:            bus = '0;
    endcase
  end

  // T2 byte carries the cycle type on top
  assign data_out = ctrl.mark_cycle ? {ctrl.cycle_type, bus[5:0]} : bus;
  assign instr    = ir;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir    <= '0;
      pc    <= '0;
      flags <= '0;
    end else begin
      if (ctrl.ir_we) ir <= bus;
      if (ctrl.flag_we) flags <= alu_flags;
      if (ctrl.pc_load) begin
        pc <= {tmp_a[5:0], tmp_b};
      end else if (ctrl.pc_inc) begin
        pc <= pc + 1'b1;
      end
    end
  end

  // Loading both temps at once puts the accumulator in A
  always_ff @(posedge clk) begin
    if (ctrl.tmp_a_we) tmp_a <= ctrl.tmp_b_we ? acc : bus;
    if (ctrl.tmp_b_we) tmp_b <= bus;
  end

endmodule

//--- hw/i8008_core.sv
`timescale 1ns/1ps

module i8008_core (
  input  logic              clk,
  input  logic              rst,
  input  i8008_pkg::data_t  data_in,
  input  logic              ready,
  output i8008_pkg::data_t  data_out,
  output i8008_pkg::state_t state
);

  i8008_pkg::ctrl_t  ctrl;
  i8008_pkg::data_t  instr;
  i8008_pkg::flags_t flags;

  i8008_sequencer i_sequencer (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .instr (instr),
    .flags (flags),
    .ctrl  (ctrl),
    .state (state)
  );

  i8008_datapath i_datapath (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out),
    .instr    (instr),
    .flags    (flags)
  );

endmodule

//--- test/i8008_asserts.sv
`timescale 1ns/1ps

module i8008_asserts (
  input logic              clk,
  input logic              rst,
  input logic              ready,
  input i8008_pkg::state_t state
);

  // Back-pressure from ready
  t2_stall: assert property (@(posedge clk) disable iff (rst)
    (state == i8008_pkg::T2 && !ready) |=> (state == i8008_pkg::WAIT))
    else $error("T2 with ready low was not followed by WAIT");

  wait_hold: assert property (@(posedge clk) disable iff (rst)
    (state == i8008_pkg::WAIT && !ready) |=> (state == i8008_pkg::WAIT))
    else $error("WAIT with ready low did not stay in WAIT");

  t1_to_t2: assert property (@(posedge clk) disable iff (rst)
    (state == i8008_pkg::T1) |=> (state == i8008_pkg::T2))
    else $error("T1 was not followed by T2");

  // Only reset leaves STOPPED
  stop_hold: assert property (@(posedge clk) disable iff (rst)
    (state == i8008_pkg::STOPPED) |=> (state == i8008_pkg::STOPPED))
    else $error("STOPPED state was left without reset");

endmodule

//--- test/tb_i8008.sv
`timescale 1ns/1ps

module tb_i8008;

  localparam int MEM_WORDS  = 1 << i8008_pkg::ADDR_W;
  localparam int STIM_WORDS = 256;

  logic                   clk;
  logic                   rst;
  logic                   ready;
  i8008_pkg::data_t       data_in;
  i8008_pkg::data_t       data_out;
  i8008_pkg::state_t      state;
  i8008_pkg::data_t       mem [MEM_WORDS];
  logic [31:0]            stim [STIM_WORDS];
  i8008_pkg::addr_t       exp_addr [$];
  i8008_pkg::data_t       exp_data [$];
  i8008_pkg::addr_t       bus_addr;
  i8008_pkg::addr_t       next_fetch;
  i8008_pkg::addr_t       operand_ptr;
  i8008_pkg::addr_t       jump_target;
  i8008_pkg::cycle_type_t bus_type;
  i8008_pkg::data_t       opcode;
  logic [31:0]            lfsr;
  int n_prog, widx, cycles, limit, stall, operands_left, jump_kind;

  i8008_core i_dut (
    .clk      (clk),
    .rst      (rst),
    .data_in  (data_in),
    .ready    (ready),
    .data_out (data_out),
    .state    (state)
  );

  bind i8008_core i8008_asserts i_asserts (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .state (state)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Jumps take three bytes, immediates two
  function automatic int instr_length(input i8008_pkg::data_t op);
    if (op[7:6] == 2'b01 && op[1:0] == 2'b00) return 3;
    if (op[7:6] == 2'b00 && op[2] && !op[0]) return 2;
    return 1;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_addr(input string name, input i8008_pkg::addr_t got,
                            input i8008_pkg::addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input i8008_pkg::data_t got,
                            input i8008_pkg::data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_state(input string name, input i8008_pkg::state_t got,
                             input i8008_pkg::state_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Follows fetch and operand addresses from the T2 byte
  task automatic track_cycle();
    case (bus_type)
      i8008_pkg::PCI: begin
        if (operands_left != 0) fail_run("Fetch started before all operand bytes were read");
        if (!(jump_kind == 2 && bus_addr == jump_target)) begin
          check_addr("fetch address", bus_addr, (jump_kind == 1) ? jump_target : next_fetch);
        end
        opcode        = mem[bus_addr];
        operands_left = instr_length(opcode) - 1;
        next_fetch    = bus_addr + i8008_pkg::addr_t'(instr_length(opcode));
        operand_ptr   = bus_addr + 14'd1;
        jump_kind     = (opcode[7:6] == 2'b01 && opcode[1:0] == 2'b00) ? (opcode[2] ? 1 : 2) : 0;
      end
      i8008_pkg::PCR: begin
        if (operands_left == 0) fail_run("Read cycle without an operand byte to read");
        check_addr("operand address", bus_addr, operand_ptr);
        if (operands_left == 2) jump_target[7:0] = mem[bus_addr];
        else jump_target[13:8] = mem[bus_addr][5:0]; // High byte comes last
        operand_ptr   = operand_ptr + 14'd1;
        operands_left = operands_left - 1;
      end
      i8008_pkg::PCW: begin
        if (widx >= exp_addr.size()) fail_run("Write cycle seen with no expected write left");
        else check_addr("write address", bus_addr, exp_addr[widx]);
      end
      default: fail_run("Unexpected I/O cycle type on the bus");
    endcase
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory model and ready stalls
  initial begin
    forever begin
      @(posedge clk);
      #2;
      case (state)
        i8008_pkg::T1: bus_addr[7:0] = data_out;
        i8008_pkg::T2: begin
          bus_addr[13:8] = data_out[5:0];
          bus_type       = i8008_pkg::cycle_type_t'(data_out[7:6]);
          track_cycle();
          lfsr  = lfsr_step(lfsr);
          stall = int'(lfsr[0]);
          lfsr  = lfsr_step(lfsr);
          stall = 2 * stall + int'(lfsr[0]);
          ready = (stall == 0);
        end
        i8008_pkg::WAIT: begin
          if (stall > 0) stall = stall - 1;
          ready = (stall == 0);
        end
        i8008_pkg::T3: begin
          if (bus_type == i8008_pkg::PCW) begin
            check_data("write data", data_out, exp_data[widx]);
            widx = widx + 1;
          end else begin
            data_in = mem[bus_addr];
          end
        end
        default: ;
      endcase
    end
  end

  initial begin
    rst = 1'b1;
    ready = 1'b1;
    data_in = '0;
    lfsr = 32'hd59e;
    {n_prog, widx, stall, operands_left, jump_kind} = '0;
    next_fetch = '0;
    jump_target = '0;
    bus_addr = '0;
    bus_type = i8008_pkg::PCI;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = i8008_pkg::data_t'(a) ^ i8008_pkg::data_t'(a >> 8) ^ 8'ha5;
    end
    for (int i = 0; i < STIM_WORDS; i++) stim[i] = '0;
    $readmemh("test/i8008_stim.dat", stim);
    foreach (stim[i]) begin
      if (stim[i][31:28] == 4'h1) begin
        mem[i8008_pkg::addr_t'(stim[i][23:8])] = stim[i][7:0];
        n_prog = n_prog + 1;
      end else if (stim[i][31:28] == 4'h2) begin
        exp_addr.push_back(i8008_pkg::addr_t'(stim[i][23:8]));
        exp_data.push_back(stim[i][7:0]);
      end
    end
    limit = n_prog * 25 + 100; // Five states per byte, five for stalls
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    check_state("state after reset", state, i8008_pkg::T1);
    cycles = 0;
    while (state != i8008_pkg::STOPPED) begin
      @(posedge clk);
      #2;
      cycles = cycles + 1;
      if (cycles >= limit) begin
        fail_run($sformatf("Timeout: the program never halted within %0d cycles", limit));
      end
    end
    repeat (20) begin
      @(posedge clk);
      #2;
      check_state("state after halt", state, i8008_pkg::STOPPED);
    end
    if (widx == exp_addr.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run($sformatf("Only %0d of %0d expected writes were seen", widx, exp_addr.size()));
    end
  end

endmodule

//--- test/i8008_stim.dat
// Each word is K0AAAADD: K=1 program byte DD at address AAAA, K=2 expected write DD to AAAA
// Program bytes first, then the expected writes in bus order
1000002E 10000120 10000236 10000300 1000040E 1000055A 100006F9 100007D1 10000830 100009FA
10000A06 10000B3C 10000C81 10000D30 10000EF8 10000F14 100010A0 10001130 100012F8 1000138A
10001430 100015F8 10001624 1000170F 1000182C 100019FF 10001A30 10001BF8 10001C02 10001D1A
10001E0A 10001F12 10002030 100021F8 10002218 10002321 10002430 100025FB 10002630 100027FC
10002806 10002940 10002A3C 10002B40 10002C68 10002D32 10002E00 10002F0E 100030EE 100031F9
1000320E 10003311 10003430 100035F9 10003606 10003710 10003814 10003920 10003A40 10003B42
10003C00 10003D0E 10003E22 10003F44 10004045 10004100 1000420E 100043EE 100044F9 10004530
100046F9 10004750 1000484D 10004900 10004A0E 10004BEE 10004CF9 10004D0E 10004E33 10004F30
100050F9 10005160 10005257 10005300 1000540E 100055EE 100056F9 1000570E 10005844 10005930
10005AF9 10005B58 10005C63 10005D00 10005E0E 10005F55 10006044 10006166 10006200 1000630E
100064EE 100065F9 10006630 100067F9 10006806 1000690F 10006AB1 10006B9B 10006CA4 10006DA9
10006E30 10006FF8 10007078 10007176 10007200 100073FF 100074FF 100075FF 100076FE 100077FF
2020005A 2020015A 20200296 202003F6 20200451 202005FE 202006FE 20200701
202008FF 20200911 20200A22 20200B33 20200C44 20200D55 20200E0B

//--- sources.f
hw/i8008_pkg.sv
hw/i8008_alu.sv
hw/i8008_regfile.sv
hw/i8008_sequencer.sv
hw/i8008_datapath.sv
hw/i8008_core.sv
test/i8008_asserts.sv
test/tb_i8008.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i8008
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
